// File: usb_defines.svh
`ifndef USB_DEFINES_SVH
`define USB_DEFINES_SVH

// ======================================================================
// Device identity
// ======================================================================

// Fixed device address, no SET_ADDRESS handling
`define DEV_ADDR 7'h05

// Number of the single bulk loopback endpoint
`define EP_NUM 4'h1

// ======================================================================
// Buffer sizing
// ======================================================================

// Entries in the endpoint FIFO, power of two
`define FIFO_DEPTH 16

// Largest IN payload in bytes
`define MAX_PACKET 8

`define BYTE_W 8

`endif

// File: usbPkg.sv
`default_nettype none

package usbPkg;

    // PID values, lower nibble as sent on the wire
    // Upper nibble of the wire byte is the inverse of this nibble
    typedef enum logic [3:0] {
        PID_OUT   = 4'd1,
        PID_ACK   = 4'd2,
        PID_DATA0 = 4'd3,
        PID_IN    = 4'd9,
        PID_NAK   = 4'd10,
        PID_SETUP = 4'd13
    } PidType;

    // Transaction controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_OUT_RECV,
        ST_OUT_RESP,
        ST_IN_SEND,
        ST_WAIT_SENT,
        ST_IN_AWAIT_HS,
        ST_FINISH
    } TransState;

    // Token packet, first byte in the low bits
    typedef struct packed {
        logic [4:0] crc5;
        logic [3:0] endp;
        logic [6:0] addr;
        logic [3:0] pidChk;
        PidType     pid;
    } TokenView;

    // Handshake packet, only the first byte is meaningful
    typedef struct packed {
        logic [15:0] pad;
        logic [3:0]  pidChk;
        PidType      pid;
    } HsView;

    typedef union packed {
        TokenView tokenView;
        HsView    hsView;
    } StartBuf;

endpackage

`default_nettype wire

// File: usbEpFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_defines.svh"

module usbEpFifo (
    input  wire                clk12_i,
    input  wire                rst_i,

    // Write side, filled by the rx front during OUT data
    input  wire                wrEn_i,
    input  wire [`BYTE_W-1:0]  wrData_i,
    input  wire                fillDone_i,
    input  wire                fillOk_i,

    // Read side, drained by the tx front during IN data
    input  wire                rdEn_i,
    output logic [`BYTE_W-1:0] rdData_o,
    input  wire                popDone_i,
    input  wire                popOk_i,

    output logic               empty_o,
    output logic               full_o
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    logic [`BYTE_W-1:0] mem [`FIFO_DEPTH];

    // Working pointers move per byte, saved pointers only on commit
    // Extra MSB tells a full buffer from an empty one
    logic [PTR_W:0] wrPtr;
    logic [PTR_W:0] wrPtrSaved;
    logic [PTR_W:0] rdPtr;
    logic [PTR_W:0] rdPtrSaved;
    logic           wrHit;
    logic           rdHit;

    // Reader only sees committed packets
    assign empty_o = rdPtr == wrPtrSaved;
    // Writer must not overwrite bytes that may still be resent
    assign full_o  = wrPtr == {~rdPtrSaved[PTR_W], rdPtrSaved[PTR_W-1:0]};

    assign wrHit    = wrEn_i && !full_o;
    assign rdHit    = rdEn_i && !empty_o;
    // Show-ahead read, head byte is always on the output
    assign rdData_o = mem[rdPtr[PTR_W-1:0]];

    always_ff @(posedge clk12_i) begin
        if (wrHit) begin
            mem[wrPtr[PTR_W-1:0]] <= wrData_i;
        end
    end

    always_ff @(posedge clk12_i) begin
        if (rst_i) begin
            wrPtr      <= '0;
            wrPtrSaved <= '0;
            rdPtr      <= '0;
            rdPtrSaved <= '0;
        end else begin
            // Write pointer, commit keeps the packet and rewind drops it
            if (fillDone_i) begin
                if (fillOk_i) begin
                    wrPtrSaved <= wrPtr;
                end else begin
                    wrPtr <= wrPtrSaved;
                end
            end else if (wrHit) begin
                wrPtr <= wrPtr + 1'b1;
            end

            // Read pointer, rewind makes the same bytes go out again
            if (popDone_i) begin
                if (popOk_i) begin
                    rdPtrSaved <= rdPtr;
                end else begin
                    rdPtr <= rdPtrSaved;
                end
            end else if (rdHit) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: usbRxFront.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_defines.svh"

module usbRxFront (
    input  wire                clk12_i,
    input  wire                rst_i,

    // Byte stream from the serial front end
    input  wire [`BYTE_W-1:0]  rxData_i,
    input  wire                rxDataValid_i,
    input  wire                rxIsLastByte_i,
    input  wire                keepPacket_i,
    output logic               rxAcceptNewData_o,

    // FIFO write side
    input  wire                fifoFull_i,
    output logic               wrEn_o,
    output logic [`BYTE_W-1:0] wrData_o,

    // Transaction controller
    input  wire                inData_i,
    input  wire                transDone_i,
    output logic               rxDone_o,
    output logic               rxOk_o,
    output logic               tokStart_o,
    output logic               isInToken_o,
    output usbPkg::PidType     rxPid_o
);

    import usbPkg::*;

    logic [3*`BYTE_W-1:0] rawBuf;
    StartBuf              startBuf;
    logic [1:0]           bufIdx;
    logic                 bufFull;
    logic                 rxBlocked;
    logic                 rxHs;
    logic                 pidValid;
    logic                 tokValid;

    // ======================================================================
    // Acceptance
    // ======================================================================

    assign bufFull = bufIdx == 2'd3;

    // OUT data is limited by the FIFO
    // Outside a transaction extra bytes are dropped so foreign traffic passes fast
    assign rxBlocked = inData_i ? fifoFull_i : (bufFull && tokStart_o);

    // Last byte is always taken, a dropped one just fails the packet
    assign rxAcceptNewData_o = (!rxDone_o && !rxBlocked) || rxIsLastByte_i;
    assign rxHs              = rxDataValid_i && rxAcceptNewData_o;

    // Front end hands over the payload only, PID and CRC16 already stripped
    assign wrEn_o   = inData_i && rxHs && !fifoFull_i;
    assign wrData_o = rxData_i;

    // ======================================================================
    // Start buffer and token check
    // ======================================================================

    assign startBuf = rawBuf;

    // Check nibble sits at the same place in both views
    assign pidValid = startBuf.hsView.pidChk == ~startBuf.hsView.pid;
    assign rxPid_o  = startBuf.hsView.pid;

    // SETUP is not handled, only bulk OUT and IN open a transaction
    assign tokValid = rxDone_o && rxOk_o && !tokStart_o && bufFull && pidValid
        && (startBuf.tokenView.pid == PID_OUT || startBuf.tokenView.pid == PID_IN)
        && startBuf.tokenView.addr == `DEV_ADDR
        && startBuf.tokenView.endp == `EP_NUM;

    // Bytes land by index, PID byte always at the bottom
    always_ff @(posedge clk12_i) begin
        if (!inData_i && rxHs && !bufFull) begin
            rawBuf[bufIdx * `BYTE_W +: `BYTE_W] <= rxData_i;
        end
    end

    always_ff @(posedge clk12_i) begin
        if (rst_i) begin
            bufIdx      <= '0;
            rxDone_o    <= 1'b0;
            rxOk_o      <= 1'b0;
            tokStart_o  <= 1'b0;
            isInToken_o <= 1'b0;
        end else begin
            if (rxDone_o) begin
                bufIdx <= '0;
            end else if (!inData_i && rxHs && !bufFull) begin
                bufIdx <= bufIdx + 1'b1;
            end

            // Single cycle done, ok only if kept and nothing was dropped
            rxDone_o <= rxHs && rxIsLastByte_i && !rxDone_o;
            rxOk_o   <= rxHs && rxIsLastByte_i && !rxDone_o && keepPacket_i && !rxBlocked;

            // Held until the controller closes the transaction
            tokStart_o <= tokStart_o ? !transDone_i : tokValid;
            if (tokValid) begin
                isInToken_o <= startBuf.tokenView.pid == PID_IN;
            end
        end
    end

endmodule

`default_nettype wire

// File: usbTxFront.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_defines.svh"

module usbTxFront (
    input  wire                clk12_i,
    input  wire                rst_i,

    // Response request from the controller
    input  wire                sendPid_i,
    input  usbPkg::PidType     pidSel_i,
    input  wire                pidOnly_i,

    // FIFO read side
    input  wire                fifoEmpty_i,
    input  wire [`BYTE_W-1:0]  rdData_i,
    output logic               rdEn_o,

    // Byte stream to the serial back end
    output logic [`BYTE_W-1:0] txData_o,
    output logic               txDataValid_o,
    output logic               txIsLastByte_o,
    input  wire                txAcceptNewData_i
);

    import usbPkg::*;

    localparam int CNT_W = $clog2(`MAX_PACKET + 1);

    logic               pidPhase;
    PidType             pidReg;
    logic [CNT_W-1:0]   fetchLeft;
    logic               holdValid;
    logic [`BYTE_W-1:0] holdByte;
    logic               txHs;

    assign txHs = txDataValid_o && txAcceptNewData_i;

    // PID byte first, then the prefetched payload byte
    assign txDataValid_o = pidPhase || holdValid;
    assign txData_o      = pidPhase ? {~pidReg, pidReg} : holdByte;

    // Nothing more follows once the budget is spent or the FIFO ran dry
    // Both only move on a fetch, so last stays stable while a byte stalls
    assign txIsLastByte_o = fetchLeft == '0 || fifoEmpty_i;

    // Fetch one byte ahead so emptiness is known before it goes out
    // No fetch during the PID byte, keeps its last flag steady
    assign rdEn_o = !pidPhase && !holdValid && fetchLeft != '0 && !fifoEmpty_i;

    always_ff @(posedge clk12_i) begin
        if (sendPid_i) begin
            pidReg <= pidSel_i;
        end
        if (rdEn_o) begin
            holdByte <= rdData_i;
        end
    end

    always_ff @(posedge clk12_i) begin
        if (rst_i) begin
            pidPhase  <= 1'b0;
            holdValid <= 1'b0;
            fetchLeft <= '0;
        end else if (sendPid_i) begin
            pidPhase  <= 1'b1;
            holdValid <= 1'b0;
            // Handshake packets carry no payload
            fetchLeft <= pidOnly_i ? '0 : CNT_W'(`MAX_PACKET);
        end else begin
            if (txHs) begin
                pidPhase  <= 1'b0;
                holdValid <= 1'b0;
            end
            if (rdEn_o) begin
                holdValid <= 1'b1;
                fetchLeft <= fetchLeft - 1'b1;
            end
            // Stop fetching after the packet, later OUT data stays put
            if (txHs && txIsLastByte_o) begin
                fetchLeft <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: usbTransCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module usbTransCtrl (
    input  wire            clk12_i,
    input  wire            rst_i,

    // Receive status
    input  wire            tokStart_i,
    input  wire            isInToken_i,
    input  wire            rxDone_i,
    input  wire            rxOk_i,
    input  usbPkg::PidType rxPid_i,

    // FIFO status
    input  wire            fifoEmpty_i,
    input  wire            fifoFull_i,

    input  wire            packetWaitTimeout_i,
    input  wire            txDoneSending_i,

    output logic           transDone_o,
    output logic           inData_o,

    // Commit and rewind
    output logic           fillDone_o,
    output logic           fillOk_o,
    output logic           popDone_o,
    output logic           popOk_o,

    // Response to the tx front
    output logic           sendPid_o,
    output usbPkg::PidType pidSel_o,
    output logic           pidOnly_o,

    output logic           txReqSendPacket_o,
    output logic           isSendingPhase_o,
    output logic           readTimerRst_o
);

    import usbPkg::*;

    TransState state;
    logic      inAwait;

    // ======================================================================
    // Outputs decoded from the state
    // ======================================================================

    assign inData_o    = state == ST_OUT_RECV;
    assign inAwait     = state == ST_IN_AWAIT_HS;
    assign transDone_o = state == ST_FINISH;

    // One issue cycle per response, request and PID go out together
    assign txReqSendPacket_o = state == ST_OUT_RESP || state == ST_IN_SEND;
    assign sendPid_o         = txReqSendPacket_o;
    assign pidOnly_o         = pidSel_o != PID_DATA0;

    // Timer runs while waiting on the host, held otherwise
    assign readTimerRst_o = state == ST_IDLE
        || ((state == ST_IN_SEND || state == ST_WAIT_SENT) && !pidOnly_o);

    // OUT packet kept on a clean receive, dropped on error or timeout
    assign fillDone_o = inData_o && (rxDone_i || packetWaitTimeout_i);
    assign fillOk_o   = inData_o && rxDone_i && rxOk_i;

    // Only a clean ACK frees the sent bytes
    assign popDone_o = inAwait && (rxDone_i || packetWaitTimeout_i);
    assign popOk_o   = inAwait && rxDone_i && rxOk_i && rxPid_i == PID_ACK;

    // ======================================================================
    // FSM
    // ======================================================================

    always_ff @(posedge clk12_i) begin
        if (rst_i) begin
            state            <= ST_IDLE;
            isSendingPhase_o <= 1'b0;
            pidSel_o         <= PID_NAK;
        end else begin
            unique case (state)
                ST_IDLE: begin
                    if (tokStart_i && isInToken_i) begin
                        // Nothing committed to send, answer NAK
                        pidSel_o         <= fifoEmpty_i ? PID_NAK : PID_DATA0;
                        isSendingPhase_o <= 1'b1;
                        state            <= ST_IN_SEND;
                    end else if (tokStart_i) begin
                        state <= ST_OUT_RECV;
                    end
                end
                ST_OUT_RECV: begin
                    if (rxDone_i && (rxOk_i || fifoFull_i)) begin
                        // Overflow gets NAK, a clean packet gets ACK
                        pidSel_o         <= rxOk_i ? PID_ACK : PID_NAK;
                        isSendingPhase_o <= 1'b1;
                        state            <= ST_OUT_RESP;
                    end else if (rxDone_i || packetWaitTimeout_i) begin
                        // Broken packet, stay silent
                        state <= ST_FINISH;
                    end
                end
                ST_OUT_RESP, ST_IN_SEND: begin
                    state <= ST_WAIT_SENT;
                end
                ST_WAIT_SENT: begin
                    if (txDoneSending_i) begin
                        isSendingPhase_o <= 1'b0;
                        // Only a data packet expects a host handshake
                        state <= pidOnly_o ? ST_FINISH : ST_IN_AWAIT_HS;
                    end
                end
                ST_IN_AWAIT_HS: begin
                    if (rxDone_i || packetWaitTimeout_i) begin
                        state <= ST_FINISH;
                    end
                end
                ST_FINISH: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: usbPe.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_defines.svh"

module usbPe (
    input  wire                clk12_i,
    input  wire                rst_i,

    // Packet timer
    output logic               readTimerRst_o,
    input  wire                packetWaitTimeout_i,

    input  wire                txDoneSending_i,
    output logic               isSendingPhase_o,

    // Receive stream
    output logic               rxAcceptNewData_o,
    input  wire [`BYTE_W-1:0]  rxData_i,
    input  wire                rxIsLastByte_i,
    input  wire                rxDataValid_i,
    input  wire                keepPacket_i,

    // Transmit stream
    output logic               txReqSendPacket_o,
    output logic               txDataValid_o,
    output logic               txIsLastByte_o,
    output logic [`BYTE_W-1:0] txData_o,
    input  wire                txAcceptNewData_i
);

    import usbPkg::*;

    // Rx front to FIFO and controller
    logic               wrEn;
    logic [`BYTE_W-1:0] wrData;
    logic               rxDone;
    logic               rxOk;
    logic               tokStart;
    logic               isInToken;
    PidType             rxPid;

    // FIFO status and read side
    logic               fifoEmpty;
    logic               fifoFull;
    logic               rdEn;
    logic [`BYTE_W-1:0] rdData;

    // Controller outputs
    logic               transDone;
    logic               inData;
    logic               fillDone;
    logic               fillOk;
    logic               popDone;
    logic               popOk;
    logic               sendPid;
    PidType             pidSel;
    logic               pidOnly;

    usbRxFront rxFront0 (
        .clk12_i          (clk12_i),
        .rst_i            (rst_i),
        .rxData_i         (rxData_i),
        .rxDataValid_i    (rxDataValid_i),
        .rxIsLastByte_i   (rxIsLastByte_i),
        .keepPacket_i     (keepPacket_i),
        .rxAcceptNewData_o(rxAcceptNewData_o),
        .fifoFull_i       (fifoFull),
        .wrEn_o           (wrEn),
        .wrData_o         (wrData),
        .inData_i         (inData),
        .transDone_i      (transDone),
        .rxDone_o         (rxDone),
        .rxOk_o           (rxOk),
        .tokStart_o       (tokStart),
        .isInToken_o      (isInToken),
        .rxPid_o          (rxPid)
    );

    usbEpFifo epFifo0 (
        .clk12_i   (clk12_i),
        .rst_i     (rst_i),
        .wrEn_i    (wrEn),
        .wrData_i  (wrData),
        .fillDone_i(fillDone),
        .fillOk_i  (fillOk),
        .rdEn_i    (rdEn),
        .rdData_o  (rdData),
        .popDone_i (popDone),
        .popOk_i   (popOk),
        .empty_o   (fifoEmpty),
        .full_o    (fifoFull)
    );

    usbTxFront txFront0 (
        .clk12_i          (clk12_i),
        .rst_i            (rst_i),
        .sendPid_i        (sendPid),
        .pidSel_i         (pidSel),
        .pidOnly_i        (pidOnly),
        .fifoEmpty_i      (fifoEmpty),
        .rdData_i         (rdData),
        .rdEn_o           (rdEn),
        .txData_o         (txData_o),
        .txDataValid_o    (txDataValid_o),
        .txIsLastByte_o   (txIsLastByte_o),
        .txAcceptNewData_i(txAcceptNewData_i)
    );

    usbTransCtrl transCtrl0 (
        .clk12_i            (clk12_i),
        .rst_i              (rst_i),
        .tokStart_i         (tokStart),
        .isInToken_i        (isInToken),
        .rxDone_i           (rxDone),
        .rxOk_i             (rxOk),
        .rxPid_i            (rxPid),
        .fifoEmpty_i        (fifoEmpty),
        .fifoFull_i         (fifoFull),
        .packetWaitTimeout_i(packetWaitTimeout_i),
        .txDoneSending_i    (txDoneSending_i),
        .transDone_o        (transDone),
        .inData_o           (inData),
        .fillDone_o         (fillDone),
        .fillOk_o           (fillOk),
        .popDone_o          (popDone),
        .popOk_o            (popOk),
        .sendPid_o          (sendPid),
        .pidSel_o           (pidSel),
        .pidOnly_o          (pidOnly),
        .txReqSendPacket_o  (txReqSendPacket_o),
        .isSendingPhase_o   (isSendingPhase_o),
        .readTimerRst_o     (readTimerRst_o)
    );

endmodule

`default_nettype wire

// File: usbPe_props.sv
`timescale 1ns/1ps
`default_nettype none

module usbPe_props (
    input wire       clk12_i,
    input wire       rst_i,
    input wire       txDataValid_i,
    input wire       txAccept_i,
    input wire       txIsLast_i,
    input wire [7:0] txData_i,
    input wire       rxValid_i,
    input wire       rxAccept_i,
    input wire       rxIsLast_i,
    input wire       rxDone_i,
    input wire       txReq_i,
    input wire       inData_i,
    input wire       readTimerRst_i,
    input wire       isSendingPhase_i
);

    // A stalled tx byte keeps its data, valid and last flag
    txHoldA: assert property (@(posedge clk12_i) disable iff (rst_i)
        txDataValid_i && !txAccept_i |=>
            txDataValid_i && $stable(txData_i) && $stable(txIsLast_i))
        else $error("tx byte changed while the back end stalled");

    // Each last-byte handshake gives exactly one receive done, one cycle later
    rxDonePulseA: assert property (@(posedge clk12_i) disable iff (rst_i)
        rxValid_i && rxAccept_i && rxIsLast_i |=> rxDone_i ##1 !rxDone_i)
        else $error("rxDone did not pulse once after the last rx byte");

    // Idle is the only state with the timer reset and no sending phase
    txReqRiseA: assert property (@(posedge clk12_i) disable iff (rst_i)
        $rose(txReq_i) |-> $past(inData_i || (readTimerRst_i && !isSendingPhase_i)))
        else $error("response request rose outside idle or OUT receive");

endmodule

bind usbPe usbPe_props props0 (
    .clk12_i         (clk12_i),
    .rst_i           (rst_i),
    .txDataValid_i   (txDataValid_o),
    .txAccept_i      (txAcceptNewData_i),
    .txIsLast_i      (txIsLastByte_o),
    .txData_i        (txData_o),
    .rxValid_i       (rxDataValid_i),
    .rxAccept_i      (rxAcceptNewData_o),
    .rxIsLast_i      (rxIsLastByte_i),
    .rxDone_i        (rxDone),
    .txReq_i         (txReqSendPacket_o),
    .inData_i        (inData),
    .readTimerRst_i  (readTimerRst_o),
    .isSendingPhase_i(isSendingPhase_o)
);

`default_nettype wire

// File: usbPe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module usbPe_tb;

    // Token PID nibbles, wire byte carries the inverse in its upper half
    localparam logic [3:0] OUT_NIB = 4'h1;
    localparam logic [3:0] IN_NIB  = 4'h9;
    localparam logic [3:0] DATA0_NIB = 4'h3;
    localparam int         WAIT_MAX = 400;

    logic       clk12_i;
    logic       rst_i;
    logic       packetWaitTimeout_i;
    logic       txDoneSending_i;
    logic [7:0] rxData_i;
    logic       rxIsLastByte_i;
    logic       rxDataValid_i;
    logic       keepPacket_i;
    logic       txAcceptNewData_i;
    wire        readTimerRst_o;
    wire        isSendingPhase_o;
    wire        rxAcceptNewData_o;
    wire        txReqSendPacket_o;
    wire        txDataValid_o;
    wire        txIsLastByte_o;
    wire  [7:0] txData_o;

    // Golden file fields
    int         fd;
    int         code;
    int         nBytes;
    int         nResp;
    int         errCount;
    int         checkCount;
    string      name;
    string      kind;
    string      respStr;
    string      line;
    logic [7:0] addr;
    logic [7:0] endp;
    logic [7:0] keepFlag;
    logic [7:0] oneByte;
    logic [7:0] respPid;
    logic [23:0] tok;
    logic [7:0] pkt[$];
    logic [7:0] expBytes[$];

    usbPe dut0 (
        .clk12_i            (clk12_i),
        .rst_i              (rst_i),
        .readTimerRst_o     (readTimerRst_o),
        .packetWaitTimeout_i(packetWaitTimeout_i),
        .txDoneSending_i    (txDoneSending_i),
        .isSendingPhase_o   (isSendingPhase_o),
        .rxAcceptNewData_o  (rxAcceptNewData_o),
        .rxData_i           (rxData_i),
        .rxIsLastByte_i     (rxIsLastByte_i),
        .rxDataValid_i      (rxDataValid_i),
        .keepPacket_i       (keepPacket_i),
        .txReqSendPacket_o  (txReqSendPacket_o),
        .txDataValid_o      (txDataValid_o),
        .txIsLastByte_o     (txIsLastByte_o),
        .txData_o           (txData_o),
        .txAcceptNewData_i  (txAcceptNewData_i)
    );

    initial begin
        clk12_i = 1'b0;
        forever #20 clk12_i = ~clk12_i;
    end

    // Back end stalls about one byte in four
    initial begin
        txAcceptNewData_i = 1'b0;
        void'($urandom(32'he501));
        forever begin
            @(posedge clk12_i);
            #2 txAcceptNewData_i = ($urandom % 4) != 0;
        end
    end

    // ======================================================================
    // Stimulus helpers
    // ======================================================================

    // Bytes of pkt, each held until the front end takes it
    task automatic sendRxPacket(input logic keep, input string stepName);
        int  t;
        logic took;
        for (int i = 0; i < pkt.size(); i++) begin
            @(posedge clk12_i);
            #2;
            rxData_i       = pkt[i];
            rxDataValid_i  = 1'b1;
            rxIsLastByte_i = i == pkt.size() - 1;
            keepPacket_i   = keep;
            took = 1'b0;
            for (t = 0; t < WAIT_MAX; t++) begin
                @(negedge clk12_i);
                if (rxAcceptNewData_o) begin
                    took = 1'b1;
                    break;
                end
            end
            if (!took) begin
                $display("%s: rx byte %0d was never accepted", stepName, i);
                errCount++;
                break;
            end
        end
        @(posedge clk12_i);
        #2;
        rxDataValid_i  = 1'b0;
        rxIsLastByte_i = 1'b0;
    endtask

    // Timer reset drops in OUT receive and while awaiting the host handshake
    task automatic waitTimerLow(input string stepName);
        int t;
        for (t = 0; t < WAIT_MAX; t++) begin
            @(negedge clk12_i);
            if (!readTimerRst_o) begin
                return;
            end
        end
        $display("%s: engine never left idle for this step", stepName);
        errCount++;
    endtask

    task automatic expectNoResponse(input string stepName);
        for (int i = 0; i < 16; i++) begin
            @(negedge clk12_i);
            if (txReqSendPacket_o) begin
                $display("%s: unexpected response request", stepName);
                errCount++;
                return;
            end
        end
    endtask

    // Collects one tx packet and checks it against respPid and expBytes
    task automatic collectResponse(input string stepName);
        int   t;
        logic seen;
        logic ended;
        logic expTimerRst;
        logic [7:0] got[$];
        logic [7:0] want[$];
        seen  = 1'b0;
        ended = 1'b0;
        for (t = 0; t < WAIT_MAX; t++) begin
            @(negedge clk12_i);
            if (txReqSendPacket_o) begin
                seen = 1'b1;
                break;
            end
        end
        if (!seen) begin
            $display("%s: no response request arrived", stepName);
            errCount++;
            return;
        end
        // Sending phase opens together with the request
        checkCount++;
        if (isSendingPhase_o !== 1'b1) begin
            $display("mismatch %s isSendingPhase exp 1 act %b", stepName, isSendingPhase_o);
            errCount++;
        end
        // Timer held only while a data payload is on its way out
        expTimerRst = respPid == {~DATA0_NIB, DATA0_NIB};
        checkCount++;
        if (readTimerRst_o !== expTimerRst) begin
            $display("mismatch %s readTimerRst exp %b act %b",
                stepName, expTimerRst, readTimerRst_o);
            errCount++;
        end
        for (t = 0; t < WAIT_MAX; t++) begin
            @(negedge clk12_i);
            if (txDataValid_o && txAcceptNewData_i) begin
                got.push_back(txData_o);
                if (txIsLastByte_o) begin
                    ended = 1'b1;
                    break;
                end
            end
        end
        if (!ended) begin
            $display("%s: response never flagged its last byte", stepName);
            errCount++;
        end
        want.push_back(respPid);
        foreach (expBytes[i]) want.push_back(expBytes[i]);
        checkCount++;
        if (got.size() != want.size()) begin
            $display("mismatch %s length exp %0d act %0d", stepName, want.size(), got.size());
            errCount++;
        end
        for (int i = 0; i < want.size() && i < got.size(); i++) begin
            checkCount++;
            if (got[i] != want[i]) begin
                $display("mismatch %s byte %0d exp %02h act %02h", stepName, i, want[i], got[i]);
                errCount++;
            end
        end
        // Back end reports the end of sending
        @(posedge clk12_i);
        #2 txDoneSending_i = 1'b1;
        @(posedge clk12_i);
        #2 txDoneSending_i = 1'b0;
        // Sending phase closes on the edge that saw the done strobe
        checkCount++;
        if (isSendingPhase_o !== 1'b0) begin
            $display("mismatch %s isSendingPhase after done exp 0 act %b",
                stepName, isSendingPhase_o);
            errCount++;
        end
    endtask

    // ======================================================================
    // Golden replay
    // ======================================================================

    initial begin
        errCount            = 0;
        checkCount          = 0;
        rst_i               = 1'b1;
        packetWaitTimeout_i = 1'b0;
        txDoneSending_i     = 1'b0;
        rxData_i            = '0;
        rxIsLastByte_i      = 1'b0;
        rxDataValid_i       = 1'b0;
        keepPacket_i        = 1'b0;
        repeat (10) @(posedge clk12_i);
        #2 rst_i = 1'b0;
        repeat (4) @(posedge clk12_i);

        fd = $fopen("usbPe_golden.txt", "r");
        if (fd == 0) begin
            $display("golden vector file could not be opened");
            errCount++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", name);
                if (code != 1) begin
                    break;
                end
                if (name.getc(0) == "#") begin
                    code = $fgets(line, fd);
                    continue;
                end
                code = $fscanf(fd, "%s %h %h %h %d", kind, addr, endp, keepFlag, nBytes);
                pkt.delete();
                for (int i = 0; i < nBytes; i++) begin
                    code = $fscanf(fd, "%h", oneByte);
                    pkt.push_back(oneByte);
                end
                code = $fscanf(fd, "%s %d", respStr, nResp);
                expBytes.delete();
                for (int i = 0; i < nResp; i++) begin
                    code = $fscanf(fd, "%h", oneByte);
                    expBytes.push_back(oneByte);
                end

                // Token layout, PID byte first, then address and endpoint, CRC5 zero
                if (kind == "out" || kind == "in") begin
                    tok = {5'b0, endp[3:0], addr[6:0], 8'h00};
                    tok[7:0] = kind == "out" ? {~OUT_NIB, OUT_NIB} : {~IN_NIB, IN_NIB};
                    pkt.delete();
                    pkt.push_back(tok[7:0]);
                    pkt.push_back(tok[15:8]);
                    pkt.push_back(tok[23:16]);
                    sendRxPacket(keepFlag[0], name);
                end else if (kind == "timeout") begin
                    waitTimerLow(name);
                    @(posedge clk12_i);
                    #2 packetWaitTimeout_i = 1'b1;
                    @(posedge clk12_i);
                    #2 packetWaitTimeout_i = 1'b0;
                end else begin
                    // Data and handshake packets
                    waitTimerLow(name);
                    sendRxPacket(keepFlag[0], name);
                end

                if (respStr == "-") begin
                    expectNoResponse(name);
                end else begin
                    code = $sscanf(respStr, "%h", respPid);
                    collectResponse(name);
                end
                repeat (4) @(posedge clk12_i);
            end
            $fclose(fd);
        end

        $display("checks %0d errors %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: usbPe_golden.txt
# name kind addr endp keep nbytes bytes... resp nresp resp_bytes...
# kind: out/in token, data, hs handshake, timeout; resp is the PID byte or - for none
t1_out out 05 1 1 0 - 0
t1_data data 05 1 1 4 11 22 33 44 d2 0
t2_in in 05 1 1 0 c3 4 11 22 33 44
t2_ack hs 05 1 1 1 d2 - 0
t2_in_empty in 05 1 1 0 5a 0
t3_out out 05 1 1 0 - 0
t3_data data 05 1 1 10 a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 d2 0
t3_in1 in 05 1 1 0 c3 8 a0 a1 a2 a3 a4 a5 a6 a7
t3_lost timeout 05 1 1 0 - 0
t3_in_retry in 05 1 1 0 c3 8 a0 a1 a2 a3 a4 a5 a6 a7
t3_ack hs 05 1 1 1 d2 - 0
t3_in2 in 05 1 1 0 c3 2 a8 a9
t3_ack2 hs 05 1 1 1 d2 - 0
t4_addr out 06 1 1 0 - 0
t4_endp in 05 2 1 0 - 0
t5_out out 05 1 1 0 - 0
t5_data data 05 1 0 3 55 66 77 - 0
t5_in in 05 1 1 0 5a 0
t6_out out 05 1 1 0 - 0
t6_data data 05 1 1 17 c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb cc cd ce cf d0 5a 0
t6_in in 05 1 1 0 5a 0
t6_out2 out 05 1 1 0 - 0
t6_data2 data 05 1 1 2 e1 e2 d2 0
t6_in2 in 05 1 1 0 c3 2 e1 e2
t6_ack hs 05 1 1 1 d2 - 0

// File: sources.f
+incdir+.
usbPkg.sv
usbEpFifo.sv
usbRxFront.sv
usbTxFront.sv
usbTransCtrl.sv
usbPe.sv
usbPe_props.sv
usbPe_tb.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module usbPe_tb -Mdir obj_dir

run: build
	./obj_dir/VusbPe_tb | tee sim.log
	grep -qx '>>> PASS' sim.log

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module usbPe_tb

clean:
	rm -rf obj_dir sim.log
